// File: Makefile
VERILATOR ?= verilator
TOP       ?= mmio_subsystem_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  := Finished with errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
	    echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // Access direction
    typedef enum logic {
        OP_LOAD,
        OP_STORE
    } access_op_t;

    // Access size, sets the byte strobe
    typedef enum logic [1:0] {
        WIDTH_BYTE,
        WIDTH_HALF,
        WIDTH_WORD
    } access_width_t;

    // Target of a decoded request
    typedef enum logic [1:0] {
        DEV_RAM,
        DEV_TIMER,
        DEV_NONE
    } device_sel_t;

endpackage : bus_pkg

`default_nettype wire

// File: source/event_timer.sv
`default_nettype none

`include "mmio_params.svh"

module event_timer (
    input  logic                                  sys_clk,
    input  logic                                  rst_n_i,
    input  logic                                  wr_en_i,
    input  logic                                  rd_en_i,
    input  logic [$clog2(`MMIO_TIMER_REGS)-1:0]   reg_idx_i,
    input  logic [`MMIO_DATA_W-1:0]               wdata_i,
    output logic [`MMIO_DATA_W-1:0]               rdata_o,
    output logic                                  irq_o
);

    localparam int IDX_W = $clog2(`MMIO_TIMER_REGS);

    // Register word indices
    localparam logic [IDX_W-1:0] REG_COUNTER = 0;
    localparam logic [IDX_W-1:0] REG_COMPARE = 1;
    localparam logic [IDX_W-1:0] REG_CONTROL = 2;

    logic [`MMIO_DATA_W-1:0] counter;
    logic [`MMIO_DATA_W-1:0] compare;
    logic                    enable;
    logic                    cnt_wr;
    logic                    match;

    assign cnt_wr = wr_en_i && (reg_idx_i == REG_COUNTER);
    assign match = enable && (counter == compare);

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            counter <= '0;
            compare <= '0;
            enable <= 1'b0;
            irq_o <= 1'b0;
        end else begin
            irq_o <= match && !cnt_wr;

            // A counter write overrides counting
            if (cnt_wr) begin
                counter <= wdata_i;
            end else if (match) begin
                counter <= '0;
            end else if (enable) begin
                counter <= counter + 1'b1;
            end

            if (wr_en_i && (reg_idx_i == REG_COMPARE)) begin
                compare <= wdata_i;
            end

            if (wr_en_i && (reg_idx_i == REG_CONTROL)) begin
                enable <= wdata_i[0];
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rd_en_i) begin
            case (reg_idx_i)
                REG_COUNTER: rdata_o <= counter;
                REG_COMPARE: rdata_o <= compare;
                REG_CONTROL: rdata_o <= {{(`MMIO_DATA_W - 1){1'b0}}, enable};
                default:     rdata_o <= '0;
            endcase
        end
    end

endmodule : event_timer

`default_nettype wire

// File: source/interrupt_controller.sv
`default_nettype none

module interrupt_controller (
    input  logic                                     sys_clk,
    input  logic                                     rst_n_i,
    input  logic [irq_pkg::IRQ_SOURCES-1:0]          irq_src_i,
    input  logic                                     irq_ack_i,
    output logic                                     irq_o,
    output logic [$clog2(irq_pkg::IRQ_SOURCES)-1:0]  irq_vector_o
);

    localparam int VEC_W = $clog2(irq_pkg::IRQ_SOURCES);

    irq_pkg::irq_state_t               state;
    logic [irq_pkg::IRQ_SOURCES-1:0]   pending;
    logic [irq_pkg::IRQ_SOURCES-1:0]   clr_mask;
    logic [VEC_W-1:0]                  next_vec;

    // Scan from the top so the lowest pending index is kept
    always_comb begin
        next_vec = '0;
        for (int i = irq_pkg::IRQ_SOURCES - 1; i >= 0; i--) begin
            if (pending[i]) begin
                next_vec = VEC_W'(i);
            end
        end
    end

    assign clr_mask = (state == irq_pkg::IRQ_WAIT_ACK && irq_ack_i)
                    ? (irq_pkg::IRQ_SOURCES)'(1) << irq_vector_o : '0;

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= irq_pkg::IRQ_IDLE;
            pending <= '0;
            irq_vector_o <= '0;
        end else begin
            // A fresh pulse wins over a clear of the same bit
            pending <= (pending & ~clr_mask) | irq_src_i;

            case (state)
                irq_pkg::IRQ_IDLE: begin
                    if (pending != '0) begin
                        irq_vector_o <= next_vec;
                        state <= irq_pkg::IRQ_WAIT_ACK;
                    end
                end
                irq_pkg::IRQ_WAIT_ACK: begin
                    if (irq_ack_i) begin
                        state <= irq_pkg::IRQ_IDLE;
                    end
                end
                default: state <= irq_pkg::IRQ_IDLE;
            endcase
        end
    end

    assign irq_o = (state == irq_pkg::IRQ_WAIT_ACK);

endmodule : interrupt_controller

`default_nettype wire

// File: source/irq_pkg.sv
`default_nettype none

package irq_pkg;

    parameter int IRQ_SOURCES = 2;

    // Source indices, lower index wins
    parameter int IRQ_TIMER = 0;
    parameter int IRQ_BUS_ERROR = 1;

    typedef enum logic {
        IRQ_IDLE,
        IRQ_WAIT_ACK
    } irq_state_t;

endpackage : irq_pkg

`default_nettype wire

// File: source/mmio_decode_stage.sv
`default_nettype none

`include "mmio_params.svh"

module mmio_decode_stage (
    input  logic                          sys_clk,
    input  logic                          rst_n_i,
    input  logic                          s1_valid_i,
    input  bus_pkg::access_op_t           s1_op_i,
    input  logic [`MMIO_ADDR_W-1:0]       s1_addr_i,
    input  logic [`MMIO_DATA_W-1:0]       s1_wdata_i,
    input  logic [`MMIO_STRB_W-1:0]       s1_strb_i,
    output logic                          s2_valid_o,
    output bus_pkg::access_op_t           s2_op_o,
    output bus_pkg::device_sel_t          s2_sel_o,
    output logic [`MMIO_ADDR_W-1:0]       s2_addr_o,
    output logic [`MMIO_DATA_W-1:0]       s2_wdata_o,
    output logic [`MMIO_STRB_W-1:0]       s2_strb_o
);

    // Window sizes in bytes
    localparam logic [`MMIO_ADDR_W-1:0] RAM_SPAN = `MMIO_ADDR_W'(`MMIO_RAM_BYTES);
    localparam logic [`MMIO_ADDR_W-1:0] TIMER_SPAN = `MMIO_ADDR_W'(`MMIO_TIMER_REGS * 4);

    logic [`MMIO_ADDR_W-1:0] ram_off;
    logic [`MMIO_ADDR_W-1:0] tmr_off;
    bus_pkg::device_sel_t    sel;

    // Addresses below a base wrap to a large offset and miss
    assign ram_off = s1_addr_i - `MMIO_RAM_BASE;
    assign tmr_off = s1_addr_i - `MMIO_TIMER_BASE;

    always_comb begin
        sel = bus_pkg::DEV_NONE;

        if (ram_off < RAM_SPAN) begin
            sel = bus_pkg::DEV_RAM;
        end else if (tmr_off < TIMER_SPAN) begin
            sel = bus_pkg::DEV_TIMER;
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s2_valid_o <= 1'b0;
        end else begin
            s2_valid_o <= s1_valid_i;
        end
    end

    always_ff @(posedge sys_clk) begin
        s2_op_o <= s1_op_i;
        s2_sel_o <= sel;
        s2_addr_o <= s1_addr_i;
        s2_wdata_o <= s1_wdata_i;
        s2_strb_o <= s1_strb_i;
    end

endmodule : mmio_decode_stage

`default_nettype wire

// File: source/mmio_params.svh
`ifndef MMIO_PARAMS_SVH
`define MMIO_PARAMS_SVH

// Bus geometry
`define MMIO_DATA_W 32
`define MMIO_ADDR_W 16
`define MMIO_STRB_W 4

// Address map
`define MMIO_RAM_BASE 16'h0000
`define MMIO_RAM_BYTES 1024
`define MMIO_TIMER_BASE 16'h1000

// Timer words: 0 counter, 1 compare, 2 control (bit 0 enable)
`define MMIO_TIMER_REGS 3

// Request to done, in cycles
`define MMIO_LATENCY 3

`endif

// File: source/mmio_request_stage.sv
`default_nettype none

`include "mmio_params.svh"

module mmio_request_stage (
    input  logic                          sys_clk,
    input  logic                          rst_n_i,
    input  logic                          req_i,
    input  bus_pkg::access_op_t           op_i,
    input  bus_pkg::access_width_t        width_i,
    input  logic [`MMIO_ADDR_W-1:0]       addr_i,
    input  logic [`MMIO_DATA_W-1:0]       wdata_i,
    output logic                          s1_valid_o,
    output bus_pkg::access_op_t           s1_op_o,
    output logic [`MMIO_ADDR_W-1:0]       s1_addr_o,
    output logic [`MMIO_DATA_W-1:0]       s1_wdata_o,
    output logic [`MMIO_STRB_W-1:0]       s1_strb_o
);

    logic [`MMIO_STRB_W-1:0] strb;
    logic [`MMIO_DATA_W-1:0] lane_data;

    // Strobe and lane placement from width and low address bits
    always_comb begin
        strb = '0;
        lane_data = wdata_i;

        case (width_i)
            bus_pkg::WIDTH_WORD: begin
                strb = '1;
            end
            bus_pkg::WIDTH_HALF: begin
                strb = `MMIO_STRB_W'(2'b11) << {addr_i[1], 1'b0};
                lane_data = wdata_i << {addr_i[1], 4'b0000};
            end
            bus_pkg::WIDTH_BYTE: begin
                strb = `MMIO_STRB_W'(1'b1) << addr_i[1:0];
                lane_data = wdata_i << {addr_i[1:0], 3'b000};
            end
            default: begin
                strb = '0;
            end
        endcase

        // Loads never write a lane
        if (op_i == bus_pkg::OP_LOAD) begin
            strb = '0;
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_o <= 1'b0;
        end else begin
            s1_valid_o <= req_i;
        end
    end

    always_ff @(posedge sys_clk) begin
        s1_op_o <= op_i;
        s1_addr_o <= addr_i;
        s1_wdata_o <= lane_data;
        s1_strb_o <= strb;
    end

endmodule : mmio_request_stage

`default_nettype wire

// File: source/mmio_subsystem.sv
`default_nettype none

`include "mmio_params.svh"

module mmio_subsystem (
    input  logic                                     sys_clk,
    input  logic                                     rst_n_i,
    input  logic                                     req_i,
    input  bus_pkg::access_op_t                      op_i,
    input  bus_pkg::access_width_t                   width_i,
    input  logic [`MMIO_ADDR_W-1:0]                  addr_i,
    input  logic [`MMIO_DATA_W-1:0]                  wdata_i,
    output logic                                     done_o,
    output logic                                     error_o,
    output logic [`MMIO_DATA_W-1:0]                  rdata_o,
    input  logic                                     irq_ack_i,
    output logic                                     irq_o,
    output logic [$clog2(irq_pkg::IRQ_SOURCES)-1:0]  irq_vector_o
);

//======================================================================
//  Request and decode pipeline
//======================================================================

    logic                     s1_valid;
    bus_pkg::access_op_t      s1_op;
    logic [`MMIO_ADDR_W-1:0]  s1_addr;
    logic [`MMIO_DATA_W-1:0]  s1_wdata;
    logic [`MMIO_STRB_W-1:0]  s1_strb;

    logic                     s2_valid;
    bus_pkg::access_op_t      s2_op;
    bus_pkg::device_sel_t     s2_sel;
    logic [`MMIO_ADDR_W-1:0]  s2_addr;
    logic [`MMIO_DATA_W-1:0]  s2_wdata;
    logic [`MMIO_STRB_W-1:0]  s2_strb;

    mmio_request_stage u_request_stage (
        .sys_clk    ( sys_clk  ),
        .rst_n_i    ( rst_n_i  ),
        .req_i      ( req_i    ),
        .op_i       ( op_i     ),
        .width_i    ( width_i  ),
        .addr_i     ( addr_i   ),
        .wdata_i    ( wdata_i  ),
        .s1_valid_o ( s1_valid ),
        .s1_op_o    ( s1_op    ),
        .s1_addr_o  ( s1_addr  ),
        .s1_wdata_o ( s1_wdata ),
        .s1_strb_o  ( s1_strb  )
    );

    mmio_decode_stage u_decode_stage (
        .sys_clk    ( sys_clk  ),
        .rst_n_i    ( rst_n_i  ),
        .s1_valid_i ( s1_valid ),
        .s1_op_i    ( s1_op    ),
        .s1_addr_i  ( s1_addr  ),
        .s1_wdata_i ( s1_wdata ),
        .s1_strb_i  ( s1_strb  ),
        .s2_valid_o ( s2_valid ),
        .s2_op_o    ( s2_op    ),
        .s2_sel_o   ( s2_sel   ),
        .s2_addr_o  ( s2_addr  ),
        .s2_wdata_o ( s2_wdata ),
        .s2_strb_o  ( s2_strb  )
    );

//======================================================================
//  Devices
//======================================================================

    logic                     ram_hit;
    logic                     tmr_hit;
    logic [`MMIO_DATA_W-1:0]  ram_rdata;
    logic [`MMIO_DATA_W-1:0]  tmr_rdata;
    logic                     timer_irq;

    assign ram_hit = s2_valid && (s2_sel == bus_pkg::DEV_RAM);
    assign tmr_hit = s2_valid && (s2_sel == bus_pkg::DEV_TIMER);

    scratch_ram u_scratch_ram (
        .sys_clk     ( sys_clk                                  ),
        .wr_en_i     ( ram_hit && (s2_op == bus_pkg::OP_STORE)  ),
        .rd_en_i     ( ram_hit && (s2_op == bus_pkg::OP_LOAD)   ),
        .word_addr_i ( s2_addr[$clog2(`MMIO_RAM_BYTES)-1:2]     ),
        .wdata_i     ( s2_wdata                                 ),
        .strb_i      ( s2_strb                                  ),
        .rdata_o     ( ram_rdata                                )
    );

    event_timer u_event_timer (
        .sys_clk   ( sys_clk                                   ),
        .rst_n_i   ( rst_n_i                                   ),
        .wr_en_i   ( tmr_hit && (s2_op == bus_pkg::OP_STORE)   ),
        .rd_en_i   ( tmr_hit && (s2_op == bus_pkg::OP_LOAD)    ),
        .reg_idx_i ( s2_addr[$clog2(`MMIO_TIMER_REGS)+1:2]     ),
        .wdata_i   ( s2_wdata                                  ),
        .rdata_o   ( tmr_rdata                                 ),
        .irq_o     ( timer_irq                                 )
    );

//======================================================================
//  Response and interrupts
//======================================================================

    logic                                resp_valid;
    logic                                resp_err;
    bus_pkg::device_sel_t                resp_sel;
    logic                                bus_err_irq;
    logic [irq_pkg::IRQ_SOURCES-1:0]     irq_src;

    // Lines up with the device read registers
    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            resp_valid <= 1'b0;
            resp_err <= 1'b0;
            resp_sel <= bus_pkg::DEV_NONE;
        end else begin
            resp_valid <= s2_valid;
            resp_err <= s2_valid && (s2_sel == bus_pkg::DEV_NONE);
            resp_sel <= s2_sel;
        end
    end

    always_comb begin
        case (resp_sel)
            bus_pkg::DEV_RAM:   rdata_o = ram_rdata;
            bus_pkg::DEV_TIMER: rdata_o = tmr_rdata;
            default:            rdata_o = '0;
        endcase
    end

    assign done_o = resp_valid;
    assign error_o = resp_err;

    // One pulse per unmapped response
    assign bus_err_irq = resp_err;

    assign irq_src[irq_pkg::IRQ_TIMER] = timer_irq;
    assign irq_src[irq_pkg::IRQ_BUS_ERROR] = bus_err_irq;

    interrupt_controller u_interrupt_controller (
        .sys_clk      ( sys_clk      ),
        .rst_n_i      ( rst_n_i      ),
        .irq_src_i    ( irq_src      ),
        .irq_ack_i    ( irq_ack_i    ),
        .irq_o        ( irq_o        ),
        .irq_vector_o ( irq_vector_o )
    );

endmodule : mmio_subsystem

`default_nettype wire

// File: source/scratch_ram.sv
`default_nettype none

`include "mmio_params.svh"

module scratch_ram (
    input  logic                                    sys_clk,
    input  logic                                    wr_en_i,
    input  logic                                    rd_en_i,
    input  logic [$clog2(`MMIO_RAM_BYTES / 4)-1:0]  word_addr_i,
    input  logic [`MMIO_DATA_W-1:0]                 wdata_i,
    input  logic [`MMIO_STRB_W-1:0]                 strb_i,
    output logic [`MMIO_DATA_W-1:0]                 rdata_o
);

    localparam int WORDS = `MMIO_RAM_BYTES / 4;

    logic [`MMIO_DATA_W-1:0] mem [WORDS];

    // Byte lane writes
    always_ff @(posedge sys_clk) begin
        if (wr_en_i) begin
            for (int k = 0; k < `MMIO_STRB_W; k++) begin
                if (strb_i[k]) begin
                    mem[word_addr_i][k*8 +: 8] <= wdata_i[k*8 +: 8];
                end
            end
        end
    end

    // Registered read, old word on a same-cycle write
    always_ff @(posedge sys_clk) begin
        if (rd_en_i) begin
            rdata_o <= mem[word_addr_i];
        end
    end

endmodule : scratch_ram

`default_nettype wire

// File: tb.f
+incdir+source
source/bus_pkg.sv
source/irq_pkg.sv
source/mmio_request_stage.sv
source/mmio_decode_stage.sv
source/scratch_ram.sv
source/event_timer.sv
source/interrupt_controller.sv
source/mmio_subsystem.sv
verification/mmio_subsystem_assertions.sv
verification/mmio_subsystem_tb.sv

// File: verification/mmio_subsystem_assertions.sv
`default_nettype none

`include "mmio_params.svh"

module mmio_subsystem_assertions (
    input logic                    sys_clk,
    input logic                    rst_n_i,
    input logic                    req_i,
    input logic [`MMIO_ADDR_W-1:0] addr_i,
    input logic                    done_o,
    input logic                    error_o,
    input logic                    irq_o,
    input logic                    irq_ack_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // Read by the testbench for its closing report
    int fail_count = 0;

    // Outside both windows of the address map
    function automatic bit unmapped(logic [`MMIO_ADDR_W-1:0] addr);
        bit in_ram;
        bit in_timer;
        in_ram = addr < `MMIO_RAM_BASE + `MMIO_RAM_BYTES;
        in_timer = addr >= `MMIO_TIMER_BASE &&
                   addr < `MMIO_TIMER_BASE + 4 * `MMIO_TIMER_REGS;
        return !in_ram && !in_timer;
    endfunction

    // Fixed three-cycle response, in both directions
    done_after_req : assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        req_i |-> ##3 done_o)
        else begin
            $error("done_o missing three cycles after req_i");
            fail_count++;
        end

    done_has_req : assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        done_o |-> $past(req_i, 3))
        else begin
            $error("done_o without a request three cycles earlier");
            fail_count++;
        end

    // Error only on the response to an unmapped request
    error_with_done : assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        error_o |-> done_o && unmapped($past(addr_i, 3)))
        else begin
            $error("error_o high without done_o for an unmapped address");
            fail_count++;
        end

    // Interrupt held until acknowledged, then released
    irq_held : assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        irq_o && !irq_ack_i |=> irq_o)
        else begin
            $error("irq_o dropped before irq_ack_i");
            fail_count++;
        end

    irq_released : assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        irq_o && irq_ack_i |=> !irq_o)
        else begin
            $error("irq_o still high after irq_ack_i");
            fail_count++;
        end

    quiet_after_reset : assert property (@(posedge sys_clk)
        $rose(rst_n_i) |-> !done_o ##1 !done_o)
        else begin
            $error("done_o high right after reset release");
            fail_count++;
        end

endmodule : mmio_subsystem_assertions

`default_nettype wire

// File: verification/mmio_subsystem_tb.sv
`default_nettype none

`include "mmio_params.svh"

module mmio_subsystem_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                                     sys_clk;
    logic                                     rst_n_i;
    logic                                     req_i;
    bus_pkg::access_op_t                      op_i;
    bus_pkg::access_width_t                   width_i;
    logic [`MMIO_ADDR_W-1:0]                  addr_i;
    logic [`MMIO_DATA_W-1:0]                  wdata_i;
    logic                                     irq_ack_i;
    logic                                     done_o;
    logic                                     error_o;
    logic [`MMIO_DATA_W-1:0]                  rdata_o;
    logic                                     irq_o;
    logic [$clog2(irq_pkg::IRQ_SOURCES)-1:0]  irq_vector_o;

    logic [15:0]             lfsr = 16'd19806;
    logic [`MMIO_DATA_W-1:0] ram_model [`MMIO_RAM_BYTES / 4];
    logic [`MMIO_DATA_W-1:0] exp_data_q [$];
    bit                      exp_check_q [$];
    bit                      exp_err_q [$];
    logic [`MMIO_DATA_W-1:0] last_rdata;
    int                      issued;
    int                      completed;
    int                      errors;

    always #50 sys_clk = ~sys_clk;

    mmio_subsystem u_mmio_subsystem (
        .sys_clk      ( sys_clk      ),
        .rst_n_i      ( rst_n_i      ),
        .req_i        ( req_i        ),
        .op_i         ( op_i         ),
        .width_i      ( width_i      ),
        .addr_i       ( addr_i       ),
        .wdata_i      ( wdata_i      ),
        .done_o       ( done_o       ),
        .error_o      ( error_o      ),
        .rdata_o      ( rdata_o      ),
        .irq_ack_i    ( irq_ack_i    ),
        .irq_o        ( irq_o        ),
        .irq_vector_o ( irq_vector_o )
    );

    bind mmio_subsystem mmio_subsystem_assertions u_assertions (
        .sys_clk   ( sys_clk   ),
        .rst_n_i   ( rst_n_i   ),
        .req_i     ( req_i     ),
        .addr_i    ( addr_i    ),
        .done_o    ( done_o    ),
        .error_o   ( error_o   ),
        .irq_o     ( irq_o     ),
        .irq_ack_i ( irq_ack_i )
    );

//======================================================================
//  Stimulus source and reference model
//======================================================================

    // Galois LFSR, taps x^16 + x^14 + x^13 + x^11
    function automatic logic take_bit();
        logic out;
        out = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], take_bit()};
        end
        return v;
    endfunction

    // Store lands on the lanes picked by width and low address bits
    function automatic logic [31:0] merge_store(logic [31:0] old, logic [31:0] data,
                                                bus_pkg::access_width_t width,
                                                logic [1:0] lane);
        logic [31:0] word;
        word = old;
        case (width)
            bus_pkg::WIDTH_WORD: begin
                word = data;
            end
            bus_pkg::WIDTH_HALF: begin
                if (lane[1]) begin
                    word[31:16] = data[15:0];
                end else begin
                    word[15:0] = data[15:0];
                end
            end
            default: begin
                word[lane*8 +: 8] = data[7:0];
            end
        endcase
        return word;
    endfunction

    function automatic bit is_unmapped(logic [15:0] addr);
        bit in_ram;
        bit in_timer;
        in_ram = addr < `MMIO_RAM_BASE + `MMIO_RAM_BYTES;
        in_timer = addr >= `MMIO_TIMER_BASE &&
                   addr < `MMIO_TIMER_BASE + 4 * `MMIO_TIMER_REGS;
        return !in_ram && !in_timer;
    endfunction

//======================================================================
//  Bus and interrupt tasks
//======================================================================

    task automatic finish_run();
        int fails;
        fails = u_mmio_subsystem.u_assertions.fail_count;
        $display("Check errors: %0d, assertion failures: %0d", errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic issue(bus_pkg::access_op_t op, bus_pkg::access_width_t width,
                         logic [15:0] addr, logic [31:0] data);
        logic [7:0] widx;
        bit         ram;
        widx = addr[9:2];
        ram = addr < `MMIO_RAM_BASE + `MMIO_RAM_BYTES;
        @(posedge sys_clk);
        req_i <= 1'b1;
        op_i <= op;
        width_i <= width;
        addr_i <= addr;
        wdata_i <= data;
        issued++;
        exp_err_q.push_back(is_unmapped(addr));
        exp_check_q.push_back(ram && op == bus_pkg::OP_LOAD);
        exp_data_q.push_back(ram_model[widx]);
        if (ram && op == bus_pkg::OP_STORE) begin
            ram_model[widx] = merge_store(ram_model[widx], data, width, addr[1:0]);
        end
    endtask

    task automatic idle_bus();
        @(posedge sys_clk);
        req_i <= 1'b0;
    endtask

    task automatic wait_done(int limit);
        int n;
        n = 0;
        while (completed != issued && n < limit) begin
            @(negedge sys_clk);
            n++;
        end
        if (completed != issued) begin
            $display("Timeout: %0d requests got no done_o", issued - completed);
            errors++;
            finish_run();
        end
    endtask

    task automatic access(bus_pkg::access_op_t op, bus_pkg::access_width_t width,
                          logic [15:0] addr, logic [31:0] data);
        issue(op, width, addr, data);
        idle_bus();
        wait_done(10);
    endtask

    task automatic wait_irq(int limit);
        int n;
        n = 0;
        do begin
            @(negedge sys_clk);
            n++;
        end while (!irq_o && n < limit);
        if (!irq_o) begin
            $display("Timeout: irq_o did not rise within %0d cycles", limit);
            errors++;
            finish_run();
        end
    endtask

    task automatic pulse_ack();
        @(posedge sys_clk);
        irq_ack_i <= 1'b1;
        @(posedge sys_clk);
        irq_ack_i <= 1'b0;
    endtask

    task automatic ack_irq(int vec);
        wait_irq(40);
        assert (irq_vector_o == vec) else begin
            $display("ERR %0t irq_vector_o expected %0d actual %0d", $time, vec, irq_vector_o);
            errors++;
        end
        pulse_ack();
        @(negedge sys_clk);
        assert (!irq_o) else begin
            $display("irq_o did not drop after the acknowledge at %0t", $time);
            errors++;
        end
    endtask

    // Clear leftover interrupts until the line stays quiet
    task automatic drain_irqs();
        int quiet;
        int n;
        quiet = 0;
        n = 0;
        while (quiet < 8 && n < 100) begin
            @(negedge sys_clk);
            n++;
            if (irq_o) begin
                pulse_ack();
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    // Response checker, in request order
    always @(negedge sys_clk) begin
        if (rst_n_i && done_o) begin
            if (exp_err_q.size() == 0) begin
                $display("done_o pulsed with no request in flight at %0t", $time);
                errors++;
            end else begin
                completed++;
                last_rdata = rdata_o;
                assert (error_o == exp_err_q[0]) else begin
                    $display("ERR %0t error_o expected %0b actual %0b",
                             $time, exp_err_q[0], error_o);
                    errors++;
                end
                assert (!exp_check_q[0] || rdata_o === exp_data_q[0]) else begin
                    $display("ERR %0t rdata_o expected %08h actual %08h",
                             $time, exp_data_q[0], rdata_o);
                    errors++;
                end
                void'(exp_err_q.pop_front());
                void'(exp_check_q.pop_front());
                void'(exp_data_q.pop_front());
            end
        end
    end

//======================================================================
//  Test sequence
//======================================================================

    initial begin
        logic [15:0] a;
        logic [31:0] c0;
        int          k;
        sys_clk = 1'b0;
        rst_n_i = 1'b0;
        req_i = 1'b0;
        op_i = bus_pkg::OP_LOAD;
        width_i = bus_pkg::WIDTH_WORD;
        addr_i = '0;
        wdata_i = '0;
        irq_ack_i = 1'b0;
        issued = 0;
        completed = 0;
        errors = 0;
        repeat (5) @(posedge sys_clk);
        rst_n_i <= 1'b1;

        // Word, half and byte stores, each read back
        for (k = 0; k < 12; k++) begin
            a = 16'(rand_bits(10));
            access(bus_pkg::OP_STORE, bus_pkg::WIDTH_WORD, a, rand_bits(32));
            access(bus_pkg::OP_LOAD, bus_pkg::WIDTH_WORD, a, '0);
            access(bus_pkg::OP_STORE, bus_pkg::WIDTH_HALF, a, rand_bits(16));
            access(bus_pkg::OP_LOAD, bus_pkg::WIDTH_WORD, a, '0);
            access(bus_pkg::OP_STORE, bus_pkg::WIDTH_BYTE, a, rand_bits(8));
            access(bus_pkg::OP_LOAD, bus_pkg::WIDTH_WORD, a, '0);
        end

        // Back-to-back burst, one request per cycle
        for (k = 0; k < 8; k++) begin
            if (k % 2 == 0) begin
                a = 16'(rand_bits(10));
                issue(bus_pkg::OP_STORE, bus_pkg::WIDTH_WORD, a, rand_bits(32));
            end else begin
                issue(bus_pkg::OP_LOAD, bus_pkg::WIDTH_WORD, a, '0);
            end
        end
        idle_bus();
        wait_done(20);

        // Unmapped loads raise the bus error interrupt
        access(bus_pkg::OP_LOAD, bus_pkg::WIDTH_WORD, 16'h2000, '0);
        ack_irq(irq_pkg::IRQ_BUS_ERROR);
        access(bus_pkg::OP_LOAD, bus_pkg::WIDTH_WORD, 16'h100C, '0);
        ack_irq(irq_pkg::IRQ_BUS_ERROR);

        // Timer match at compare 20
        access(bus_pkg::OP_STORE, bus_pkg::WIDTH_WORD, 16'h1004, 32'd20);
        access(bus_pkg::OP_STORE, bus_pkg::WIDTH_WORD, 16'h1008, 32'd1);
        ack_irq(irq_pkg::IRQ_TIMER);
        access(bus_pkg::OP_LOAD, bus_pkg::WIDTH_WORD, 16'h1004, '0);
        assert (last_rdata == 32'd20) else begin
            $display("ERR %0t rdata_o expected %08h actual %08h", $time, 32'd20, last_rdata);
            errors++;
        end
        access(bus_pkg::OP_STORE, bus_pkg::WIDTH_WORD, 16'h1008, 32'd0);
        access(bus_pkg::OP_LOAD, bus_pkg::WIDTH_WORD, 16'h1000, '0);
        c0 = last_rdata;
        access(bus_pkg::OP_LOAD, bus_pkg::WIDTH_WORD, 16'h1000, '0);
        assert (last_rdata == c0) else begin
            $display("ERR %0t rdata_o expected %08h actual %08h", $time, c0, last_rdata);
            errors++;
        end
        drain_irqs();

        // Timer and bus error pending together
        access(bus_pkg::OP_STORE, bus_pkg::WIDTH_WORD, 16'h1004, 32'd5);
        access(bus_pkg::OP_STORE, bus_pkg::WIDTH_WORD, 16'h1000, 32'd0);
        // Compare 5 puts the match in the same cycle as the bus error
        issue(bus_pkg::OP_STORE, bus_pkg::WIDTH_WORD, 16'h1008, 32'd1);
        for (k = 0; k < 5; k++) begin
            issue(bus_pkg::OP_LOAD, bus_pkg::WIDTH_WORD, a, '0);
        end
        issue(bus_pkg::OP_LOAD, bus_pkg::WIDTH_WORD, 16'h2000, '0);
        issue(bus_pkg::OP_STORE, bus_pkg::WIDTH_WORD, 16'h1008, 32'd0);
        idle_bus();
        wait_done(20);
        ack_irq(irq_pkg::IRQ_TIMER);
        ack_irq(irq_pkg::IRQ_BUS_ERROR);
        drain_irqs();

        repeat (3) @(posedge sys_clk);
        finish_run();
    end

endmodule : mmio_subsystem_tb

`default_nettype wire
